// ==== include/stepper_settings.svh ====
`ifndef STEPPER_SETTINGS_SVH
`define STEPPER_SETTINGS_SVH

`define STEPPER_ADDR_W      8
`define STEPPER_DATA_W      32

// Clocks per interval unit, small so moves stay short in simulation
`define STEPPER_PRESCALE    16

`define STEPPER_REG_CMD0    8'h00
`define STEPPER_REG_CMD1    8'h04
`define STEPPER_REG_STATUS  8'h08
`define STEPPER_REG_POS0    8'h0C
`define STEPPER_REG_POS1    8'h10

`endif

// ==== hdl/stepper_pkg.sv ====
package stepper_pkg;

    // One move command as written over APB
    typedef struct packed {
        logic        reserved;   // Unused, reads back as written
        logic        hold;       // Keep coils on when idle
        logic        half;       // Half-step mode
        logic        dir;        // 1 walks the table backwards
        logic [11:0] interval;   // Step every (interval+1) prescaler periods
        logic [15:0] steps;      // Number of steps
    } axis_cmd_s;

    // Register block sees the raw word, the axis decodes the fields
    typedef union packed {
        logic [31:0] raw;
        axis_cmd_s   fld;
    } axis_cmd_u;

    // Coil drive pattern, a1 is the MSB
    typedef struct packed {
        logic a1;
        logic a2;
        logic b1;
        logic b2;
    } phase_s;

    typedef logic signed [15:0] pos_t;      // Position in half-steps
    typedef logic [2:0]         phase_idx_t; // Index into the phase table

endpackage

// ==== hdl/axis_if.sv ====
// Command and status path between the register block and one axis
interface axis_if;

    stepper_pkg::axis_cmd_u cmd;    // Command word, valid with start
    logic                   start;  // One-cycle pulse
    logic                   busy;   // Move in progress
    stepper_pkg::pos_t      pos;    // Current position

    modport ctrl (
        output cmd,
        output start,
        input  busy,
        input  pos
    );

    modport axis (
        input  cmd,
        input  start,
        output busy,
        output pos
    );

endinterface

// ==== hdl/stepper_axis.sv ====
`include "stepper_settings.svh"

module stepper_axis (
    input  logic                CLK,
    input  logic                rst_n,
    axis_if.axis                bus,
    output stepper_pkg::phase_s phase,
    output logic                pwm_a,
    output logic                pwm_b
);

    localparam int PRESC = `STEPPER_PRESCALE;
    localparam int PW    = (PRESC > 1) ? $clog2(PRESC) : 1;

    stepper_pkg::axis_cmd_u  cmd_q;
    stepper_pkg::phase_idx_t idx_q;
    stepper_pkg::phase_idx_t idx_next;
    stepper_pkg::pos_t       pos_q;
    stepper_pkg::pos_t       delta;
    logic [PW-1:0]           presc_cnt;
    logic [11:0]             ival_cnt;
    logic [15:0]             steps_left;
    logic                    busy_q;
    logic                    presc_wrap;
    logic                    step;

    // Half-step sequence, a1 a2 b1 b2
    function automatic stepper_pkg::phase_s phase_lut(stepper_pkg::phase_idx_t idx);
        case (idx)
            3'd0:    phase_lut = 4'b1010;
            3'd1:    phase_lut = 4'b0010;
            3'd2:    phase_lut = 4'b0110;
            3'd3:    phase_lut = 4'b0100;
            3'd4:    phase_lut = 4'b0101;
            3'd5:    phase_lut = 4'b0001;
            3'd6:    phase_lut = 4'b1001;
            default: phase_lut = 4'b1000;
        endcase
    endfunction

    assign presc_wrap = (presc_cnt == PW'(PRESC - 1));
    assign step       = busy_q && (steps_left != '0) && presc_wrap
                        && (ival_cnt == cmd_q.fld.interval);

    // Signed step size, also applied to the table index
    always_comb begin
        delta = cmd_q.fld.half ? 16'sd1 : 16'sd2;
        if (cmd_q.fld.dir) begin
            delta = -delta;
        end
    end

    assign idx_next = idx_q + delta[2:0];    // Wraps modulo 8

    // Command latch and step counter
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q      <= '0;
            busy_q     <= 1'b0;
            steps_left <= '0;
        end else if (bus.start) begin
            cmd_q      <= bus.cmd;
            busy_q     <= 1'b1;
            steps_left <= bus.cmd.fld.steps;
        end else if (busy_q) begin
            if (steps_left == '0) begin
                busy_q <= 1'b0;                 // Empty move, one busy cycle
            end else if (step) begin
                steps_left <= steps_left - 16'd1;
                if (steps_left == 16'd1) begin
                    busy_q <= 1'b0;             // Drops on the last step
                end
            end
        end
    end

    // Prescaler and interval timer
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
            ival_cnt  <= '0;
        end else if (bus.start) begin
            presc_cnt <= '0;
            ival_cnt  <= '0;
        end else if (busy_q) begin
            if (presc_wrap) begin
                presc_cnt <= '0;
                ival_cnt  <= step ? 12'd0 : ival_cnt + 12'd1;
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

    // Phase index, position and registered coil pattern
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            idx_q <= '0;
            pos_q <= '0;
            phase <= 4'b1010;
        end else if (step) begin
            idx_q <= idx_next;
            pos_q <= pos_q + delta;
            phase <= phase_lut(idx_next);
        end
    end

    assign bus.busy = busy_q;
    assign bus.pos  = pos_q;

    // Coil enables follow the energized winding
    assign pwm_a = (busy_q | cmd_q.fld.hold) & (phase.a1 | phase.a2);
    assign pwm_b = (busy_q | cmd_q.fld.hold) & (phase.b1 | phase.b2);

endmodule

// ==== hdl/stepper_regs.sv ====
`include "stepper_settings.svh"

module stepper_regs (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`STEPPER_ADDR_W-1:0] paddr,
    input  logic [`STEPPER_DATA_W-1:0] pwdata,
    output logic [`STEPPER_DATA_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    axis_if.ctrl                       ax0,
    axis_if.ctrl                       ax1
);

    localparam int DW = `STEPPER_DATA_W;

    stepper_pkg::axis_cmd_u cmd0_q;
    stepper_pkg::axis_cmd_u cmd1_q;
    logic                   start0_q;
    logic                   start1_q;
    logic                   access;
    logic                   wr;
    logic                   sel_cmd0;
    logic                   sel_cmd1;
    logic                   sel_status;
    logic                   sel_pos0;
    logic                   sel_pos1;
    logic                   mapped;
    logic                   busy0;
    logic                   busy1;
    logic                   go0;
    logic                   go1;
    logic                   wr_err;

    assign access = psel & penable;     // No wait states
    assign wr     = access & pwrite;

    assign sel_cmd0   = (paddr == `STEPPER_REG_CMD0);
    assign sel_cmd1   = (paddr == `STEPPER_REG_CMD1);
    assign sel_status = (paddr == `STEPPER_REG_STATUS);
    assign sel_pos0   = (paddr == `STEPPER_REG_POS0);
    assign sel_pos1   = (paddr == `STEPPER_REG_POS1);
    assign mapped     = sel_cmd0 | sel_cmd1 | sel_status | sel_pos0 | sel_pos1;

    // A start still in flight counts as busy
    assign busy0 = ax0.busy | start0_q;
    assign busy1 = ax1.busy | start1_q;

    assign go0 = wr & sel_cmd0 & ~busy0;
    assign go1 = wr & sel_cmd1 & ~busy1;

    // Busy axis or read-only target
    assign wr_err = wr & ((sel_cmd0 & busy0) | (sel_cmd1 & busy1)
                          | sel_status | sel_pos0 | sel_pos1);

    assign pready  = 1'b1;
    assign pslverr = (access & ~mapped) | wr_err;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            start0_q <= 1'b0;
            start1_q <= 1'b0;
            cmd0_q   <= '0;
            cmd1_q   <= '0;
        end else begin
            start0_q <= go0;                 // Pulse one cycle after access
            start1_q <= go1;
            if (go0) begin
                cmd0_q.raw <= pwdata;
            end
            if (go1) begin
                cmd1_q.raw <= pwdata;
            end
        end
    end

    assign ax0.cmd   = cmd0_q;
    assign ax0.start = start0_q;
    assign ax1.cmd   = cmd1_q;
    assign ax1.start = start1_q;

    // Readback mux
    always_comb begin
        case (paddr)
            `STEPPER_REG_CMD0:   prdata = cmd0_q.raw;
            `STEPPER_REG_CMD1:   prdata = cmd1_q.raw;
            `STEPPER_REG_STATUS: prdata = DW'({ax1.busy, ax0.busy});
            `STEPPER_REG_POS0:   prdata = DW'(ax0.pos);   // Sign extended
            `STEPPER_REG_POS1:   prdata = DW'(ax1.pos);
            default:             prdata = '0;
        endcase
    end

endmodule

// ==== hdl/stepper_ctrl.sv ====
`include "stepper_settings.svh"

module stepper_ctrl (
    input  logic                       CLK,
    input  logic                       rst_n,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`STEPPER_ADDR_W-1:0] paddr,
    input  logic [`STEPPER_DATA_W-1:0] pwdata,
    output logic [`STEPPER_DATA_W-1:0] prdata,
    output logic                       pready,
    output logic                       pslverr,
    output logic                       phase0_a1,
    output logic                       phase0_a2,
    output logic                       phase0_b1,
    output logic                       phase0_b2,
    output logic                       pwm0_a,
    output logic                       pwm0_b,
    output logic                       phase1_a1,
    output logic                       phase1_a2,
    output logic                       phase1_b1,
    output logic                       phase1_b2,
    output logic                       pwm1_a,
    output logic                       pwm1_b
);

    axis_if ax0_if ();
    axis_if ax1_if ();

    stepper_regs u_regs (
        .CLK     (CLK),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ax0     (ax0_if.ctrl),
        .ax1     (ax1_if.ctrl)
    );

    stepper_axis u_axis0 (
        .CLK   (CLK),
        .rst_n (rst_n),
        .bus   (ax0_if.axis),
        .phase ({phase0_a1, phase0_a2, phase0_b1, phase0_b2}),
        .pwm_a (pwm0_a),
        .pwm_b (pwm0_b)
    );

    stepper_axis u_axis1 (
        .CLK   (CLK),
        .rst_n (rst_n),
        .bus   (ax1_if.axis),
        .phase ({phase1_a1, phase1_a2, phase1_b1, phase1_b2}),
        .pwm_a (pwm1_a),
        .pwm_b (pwm1_b)
    );

endmodule

// ==== sim/stepper_ctrl_chk.sv ====
module stepper_ctrl_chk (
    input logic       CLK,
    input logic       rst_n,
    input logic       pready,
    input logic [3:0] ph0,
    input logic [3:0] ph1,
    input logic [1:0] pwm0,
    input logic [1:0] pwm1,
    input logic [1:0] idle_cold     // Per axis, not busy and hold clear
);
    timeunit 1ns;
    timeprecision 1ps;

    // Both ends of one winding high would short the driver
    coil0_ok: assert property (@(posedge CLK) disable iff (!rst_n)
        !(ph0[3] && ph0[2]) && !(ph0[1] && ph0[0])) else $error("axis 0 coil driven both ways");
    coil1_ok: assert property (@(posedge CLK) disable iff (!rst_n)
        !(ph1[3] && ph1[2]) && !(ph1[1] && ph1[0])) else $error("axis 1 coil driven both ways");

    ready_ok: assert property (@(posedge CLK) pready) else $error("pready went low");

    pwm0_off: assert property (@(posedge CLK) disable iff (!rst_n)
        idle_cold[0] |-> pwm0 == 2'b00) else $error("axis 0 pwm on while idle without hold");
    pwm1_off: assert property (@(posedge CLK) disable iff (!rst_n)
        idle_cold[1] |-> pwm1 == 2'b00) else $error("axis 1 pwm on while idle without hold");

endmodule

bind stepper_ctrl stepper_ctrl_chk u_chk (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .pready    (pready),
    .ph0       ({phase0_a1, phase0_a2, phase0_b1, phase0_b2}),
    .ph1       ({phase1_a1, phase1_a2, phase1_b1, phase1_b2}),
    .pwm0      ({pwm0_a, pwm0_b}),
    .pwm1      ({pwm1_a, pwm1_b}),
    .idle_cold ({~ax1_if.busy & ~u_axis1.cmd_q.fld.hold, ~ax0_if.busy & ~u_axis0.cmd_q.fld.hold})
);

// ==== sim/tb_stepper_ctrl.sv ====
`include "stepper_settings.svh"

module tb_stepper_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         PRESC = `STEPPER_PRESCALE;
    localparam logic [3:0] PHASE_TABLE [8] = '{4'b1010, 4'b0010, 4'b0110, 4'b0100,
                                                4'b0101, 4'b0001, 4'b1001, 4'b1000};
    // Two unmapped reads, then writes to the read-only registers
    localparam logic [7:0] BAD_ADDR [5] = '{8'h14, 8'hFC, `STEPPER_REG_STATUS,
                                           `STEPPER_REG_POS0, `STEPPER_REG_POS1};

    logic                       CLK;
    logic                       rst_n;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`STEPPER_ADDR_W-1:0] paddr;
    logic [`STEPPER_DATA_W-1:0] pwdata;
    logic [`STEPPER_DATA_W-1:0] prdata;
    logic                       pready;
    logic                       pslverr;
    logic [1:0][3:0]            ph;                         // Coil pins per axis, a1 a2 b1 b2
    logic [1:0][1:0]            pwm;                        // Enables per axis, a then b
    integer                     seed;
    int                         idx_m [2] = '{0, 0};        // Model phase index
    stepper_pkg::pos_t          pos_m [2] = '{16'sd0, 16'sd0};
    logic                       hold_m [2] = '{1'b0, 1'b0};
    logic [31:0]                rd;
    stepper_pkg::axis_cmd_u     cmd_a;
    stepper_pkg::axis_cmd_u     cmd_b;

    stepper_ctrl dut (
        .CLK, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .phase0_a1(ph[0][3]), .phase0_a2(ph[0][2]), .phase0_b1(ph[0][1]), .phase0_b2(ph[0][0]),
        .phase1_a1(ph[1][3]), .phase1_a2(ph[1][2]), .phase1_b1(ph[1][1]), .phase1_b2(ph[1][0]),
        .pwm0_a(pwm[0][1]), .pwm0_b(pwm[0][0]), .pwm1_a(pwm[1][1]), .pwm1_b(pwm[1][0])
    );

    always #4 CLK = ~CLK;

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("Some tests failed");
        $fatal(1, "Stopping after the first failure");
    endtask

    task automatic mismatch(input string msg);
        stop_run($sformatf("Error at %0t ns: %s", $time, msg));
    endtask

    task automatic check_phase(input stepper_pkg::phase_s got, exp, input string what);
        if (got !== exp)
            mismatch($sformatf("%s phase %b, expected %b", what, got, exp));
    endtask

    task automatic check_pos(input stepper_pkg::pos_t got, exp, input string what);
        if (got !== exp)
            mismatch($sformatf("%s position %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_status(input logic [1:0] got, exp, input string what);
        if (got !== exp)
            mismatch($sformatf("%s busy bits %b, expected %b", what, got, exp));
    endtask

    task automatic check_pwm(input logic [1:0] got, exp, input string what);
        if (got !== exp)
            mismatch($sformatf("%s pwm a/b %b, expected %b", what, got, exp));
    endtask

    task automatic check_err(input logic got, exp, input string what);
        if (got !== exp)
            mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    // One zero-wait APB transfer, response sampled mid access phase
    task automatic apb(input logic wr, input logic [`STEPPER_ADDR_W-1:0] addr,
                       input logic [31:0] wdata, input logic exp_err, output logic [31:0] rdata);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        rdata = prdata;
        check_err(pslverr, exp_err, $sformatf("pslverr at address %h", addr));
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic int move_cycles(input stepper_pkg::axis_cmd_u c);
        return int'(c.fld.steps) * (int'(c.fld.interval) + 1) * PRESC + 8;
    endfunction

    function automatic stepper_pkg::axis_cmd_u rand_cmd(input int lo, input int hi);
        stepper_pkg::axis_cmd_u c;
        c.raw          = '0;
        c.fld.steps    = 16'(lo + $unsigned($random(seed)) % (hi - lo + 1));
        c.fld.interval = 12'($unsigned($random(seed)) % 4);
        c.fld.dir      = 1'($random(seed));
        c.fld.half     = 1'($random(seed));
        c.fld.hold     = 1'($random(seed));
        return c;
    endfunction

    // Applies all steps of an accepted command in one go
    task automatic model_move(input int ax, input stepper_pkg::axis_cmd_u c);
        int d;
        d = (c.fld.half ? 1 : 2) * (c.fld.dir ? -1 : 1);    // Half-steps per step
        hold_m[ax] = c.fld.hold;
        repeat (c.fld.steps) begin
            idx_m[ax] = (idx_m[ax] + d) & 7;                // Table index wraps modulo 8
            pos_m[ax] = pos_m[ax] + stepper_pkg::pos_t'(d);
        end
    endtask

    task automatic wait_busy(input int ax, input logic level, input int limit);
        @(negedge CLK);
        for (int n = 0; (ax ? dut.ax1_if.busy : dut.ax0_if.busy) !== level; n++) begin
            if (n == limit)
                stop_run($sformatf("Axis %0d busy did not go to %b in time", ax, level));
            else
                @(negedge CLK);
        end
    endtask

    task automatic verify_axis(input int ax);
        stepper_pkg::phase_s exp;
        logic [31:0]         r;
        string               tag;
        tag = $sformatf("axis %0d", ax);
        exp = PHASE_TABLE[idx_m[ax]];
        check_phase(ph[ax], exp, tag);
        check_pwm(pwm[ax], {hold_m[ax] & (exp.a1 | exp.a2), hold_m[ax] & (exp.b1 | exp.b2)}, tag);
        apb(1'b0, ax ? `STEPPER_REG_POS1 : `STEPPER_REG_POS0, '0, 1'b0, r);
        check_pos(stepper_pkg::pos_t'(r[15:0]), pos_m[ax], tag);
        check_pos(stepper_pkg::pos_t'(r[31:16]), {16{pos_m[ax][15]}}, {tag, " upper half"});
    endtask

    task automatic run_move(input int ax, input stepper_pkg::axis_cmd_u c);
        stepper_pkg::phase_s start_ph;
        start_ph = PHASE_TABLE[idx_m[ax]];
        apb(1'b1, ax ? `STEPPER_REG_CMD1 : `STEPPER_REG_CMD0, c.raw, 1'b0, rd);
        model_move(ax, c);
        wait_busy(ax, 1'b1, 4);
        // First step is a full interval away, coils still on the old entry
        check_pwm(pwm[ax], {start_ph.a1 | start_ph.a2, start_ph.b1 | start_ph.b2},
                  "pwm while busy");
        if (c.fld.steps != 0) begin
            apb(1'b0, `STEPPER_REG_STATUS, '0, 1'b0, rd);
            check_status(rd[1:0], ax ? 2'b10 : 2'b01, "STATUS with one axis running");
        end
        wait_busy(ax, 1'b0, move_cycles(c));
        verify_axis(ax);
    endtask

    initial begin
        seed    = 7;
        CLK     = 1'b0;
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (3) @(posedge CLK);
        rst_n <= 1'b1;
        @(negedge CLK);

        verify_axis(0);                                     // Reset state
        verify_axis(1);
        apb(1'b0, `STEPPER_REG_STATUS, '0, 1'b0, rd);
        check_status(rd[1:0], 2'b00, "STATUS after reset");

        repeat (12) begin                                   // One axis at a time
            run_move(0, rand_cmd(0, 20));
            run_move(1, rand_cmd(0, 20));
        end

        repeat (4) begin                                    // Both axes at once
            cmd_a = rand_cmd(5, 20);
            cmd_b = rand_cmd(5, 20);
            apb(1'b1, `STEPPER_REG_CMD0, cmd_a.raw, 1'b0, rd);
            apb(1'b1, `STEPPER_REG_CMD1, cmd_b.raw, 1'b0, rd);
            model_move(0, cmd_a);
            model_move(1, cmd_b);
            apb(1'b0, `STEPPER_REG_STATUS, '0, 1'b0, rd);
            check_status(rd[1:0], 2'b11, "STATUS with both axes running");
            apb(1'b1, `STEPPER_REG_CMD0, $random(seed), 1'b1, rd);   // Busy axis rejects
            apb(1'b1, `STEPPER_REG_CMD1, $random(seed), 1'b1, rd);
            wait_busy(0, 1'b0, move_cycles(cmd_a));
            wait_busy(1, 1'b0, move_cycles(cmd_b));
            verify_axis(0);
            verify_axis(1);
        end

        for (int i = 0; i < 5; i++)
            apb(i >= 2, BAD_ADDR[i], '1, 1'b1, rd);
        apb(1'b0, `STEPPER_REG_STATUS, '0, 1'b0, rd);
        check_status(rd[1:0], 2'b00, "STATUS after rejected accesses");
        verify_axis(0);
        verify_axis(1);

        for (int k = 0; k < 8; k++) begin                   // Alternating runs on axis 1
            cmd_a              = rand_cmd(0, 40);
            cmd_a.fld.dir      = k[0];
            cmd_a.fld.half     = k[1];
            cmd_a.fld.interval = '0;
            if (!k[0])
                cmd_a.fld.steps = cmd_a.fld.steps + 16'd9000;   // Pushes past the signed limit
            run_move(1, cmd_a);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
hdl/stepper_pkg.sv
hdl/axis_if.sv
hdl/stepper_axis.sv
hdl/stepper_regs.sv
hdl/stepper_ctrl.sv
sim/stepper_ctrl_chk.sv
sim/tb_stepper_ctrl.sv

// ==== Bender.yml ====
package:
  name: stepper_ctrl

sources:
  - include_dirs:
      - include
    files:
      - hdl/stepper_pkg.sv
      - hdl/axis_if.sv
      - hdl/stepper_axis.sv
      - hdl/stepper_regs.sv
      - hdl/stepper_ctrl.sv
      - target: test
        files:
          - sim/stepper_ctrl_chk.sv
          - sim/tb_stepper_ctrl.sv
